// File: logic/cnn_stream_pkg.sv
/* widths, lane ratio and data types of the streaming image path */
`default_nettype none

package cnn_stream_pkg;

   // external stream word, also the FIFO entry width
   localparam int WIDE_W = 128;

   // one pixel lane inside the processing path
   localparam int LANE_W = 32;

   // lanes per wide word, low lane first
   localparam int LANES = WIDE_W / LANE_W;
   localparam int LANE_IDX_W = 2;

   typedef logic [WIDE_W-1:0] wide_word_t;
   typedef logic [LANE_W-1:0] lane_t;

endpackage

`default_nettype wire

// File: logic/cnn_ctrl_pkg.sv
/* block gate states and block counter width */
`default_nettype none

package cnn_ctrl_pkg;

   // block counters and FIFO fill levels
   localparam int BLOCK_CNT_W = 8;

   typedef enum logic [0:0] {
      GATE_IDLE,  // waiting for enough buffered words
      GATE_RUN    // passing one block
   } gate_state_t;

endpackage

`default_nettype wire

// File: logic/stream_fifo.sv
/* synchronous FIFO of wide stream words with fill level,
   registered full flag and combinational head word */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
   parameter int FIFO_DEPTH = 32
)
(
   input  wire logic                               clk,
   input  wire logic                               cnn_rst_n,
   input  wire logic                               push,
   input  wire cnn_stream_pkg::wide_word_t         push_data,
   input  wire logic                               pop,
   output logic                                    full,
   output logic                                    nonempty,
   output cnn_stream_pkg::wide_word_t              head_data,
   output logic [cnn_ctrl_pkg::BLOCK_CNT_W-1:0]    level
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = cnn_ctrl_pkg::BLOCK_CNT_W;

   cnn_stream_pkg::wide_word_t mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] level_next;
   logic push_ok;
   logic pop_ok;

   assign push_ok = push && !full;
   assign pop_ok = pop && nonempty;
   assign nonempty = (level != '0);
   assign head_data = mem[rd_ptr];

   always_comb
   begin
      case ({push_ok, pop_ok})
         2'b10:   level_next = level + CNT_W'(1);
         2'b01:   level_next = level - CNT_W'(1);
         default: level_next = level;
      endcase
   end

   // pointers, level and full flag
   // full is held high through reset so nothing is taken early
   always_ff @(posedge clk)
   begin
      if (!cnn_rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
         full   <= 1'b1;
      end
      else
      begin
         if (push_ok)
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
         if (pop_ok)
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
         level <= level_next;
         full  <= (level_next == CNT_W'(FIFO_DEPTH));
      end
   end

   // storage
   always_ff @(posedge clk)
   begin
      if (push_ok)
         mem[wr_ptr] <= push_data;
   end

endmodule

`default_nettype wire

// File: logic/block_gate.sv
/* block gate that holds back FIFO words until a threshold
   is buffered, then passes exactly one block */
`timescale 1ns/1ps
`default_nettype none

module block_gate #(
   parameter int THRESHOLD = 8,
   parameter int BLOCK_LEN = 8
)
(
   input  wire logic                               clk,
   input  wire logic                               cnn_rst_n,
   input  wire logic [cnn_ctrl_pkg::BLOCK_CNT_W-1:0] level,
   input  wire logic                               nonempty,
   input  wire cnn_stream_pkg::wide_word_t         head_data,
   input  wire logic                               out_ready,
   output logic                                    pop,
   output logic                                    out_valid,
   output cnn_stream_pkg::wide_word_t              out_data
);

   localparam int CNT_W = cnn_ctrl_pkg::BLOCK_CNT_W;

   cnn_ctrl_pkg::gate_state_t state;
   logic [CNT_W-1:0] remaining;

   // the head word goes straight through while running
   assign out_valid = (state == cnn_ctrl_pkg::GATE_RUN) && nonempty;
   assign out_data = head_data;
   assign pop = out_valid && out_ready;

   always_ff @(posedge clk)
   begin
      if (!cnn_rst_n)
      begin
         state     <= cnn_ctrl_pkg::GATE_IDLE;
         remaining <= '0;
      end
      else
      begin
         case (state)
            cnn_ctrl_pkg::GATE_IDLE:
            begin
               if (level >= CNT_W'(THRESHOLD))
               begin
                  state     <= cnn_ctrl_pkg::GATE_RUN;
                  remaining <= CNT_W'(BLOCK_LEN);
               end
            end
            default:
            begin
               // last word of the block ends the run on the same edge
               if (pop)
               begin
                  remaining <= remaining - CNT_W'(1);
                  if (remaining == CNT_W'(1))
                     state <= cnn_ctrl_pkg::GATE_IDLE;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/width_splitter.sv
/* wide word to narrow lane splitter, low lane first */
`timescale 1ns/1ps
`default_nettype none

module width_splitter
(
   input  wire logic                       clk,
   input  wire logic                       cnn_rst_n,
   input  wire logic                       word_valid,
   input  wire cnn_stream_pkg::wide_word_t word_data,
   input  wire logic                       lane_ready,
   output logic                            word_ready,
   output logic                            lane_valid,
   output cnn_stream_pkg::lane_t           lane_data
);

   localparam int IDX_W = cnn_stream_pkg::LANE_IDX_W;

   cnn_stream_pkg::wide_word_t word_q;
   logic [IDX_W-1:0] lane_idx;
   logic last_lane_out;

   assign last_lane_out = lane_valid && lane_ready &&
                          (lane_idx == IDX_W'(cnn_stream_pkg::LANES - 1));
   assign word_ready = !lane_valid || last_lane_out;
   assign lane_data = word_q[lane_idx*cnn_stream_pkg::LANE_W +: cnn_stream_pkg::LANE_W];

   always_ff @(posedge clk)
   begin
      if (!cnn_rst_n)
      begin
         lane_valid <= 1'b0;
         lane_idx   <= '0;
      end
      else if (word_valid && word_ready)
      begin
         lane_valid <= 1'b1;
         lane_idx   <= '0;
      end
      else if (last_lane_out)
         lane_valid <= 1'b0;
      else if (lane_valid && lane_ready)
         lane_idx <= lane_idx + IDX_W'(1);
   end

   // held word, payload only
   always_ff @(posedge clk)
   begin
      if (word_valid && word_ready)
         word_q <= word_data;
   end

endmodule

`default_nettype wire

// File: logic/pixel_delay_line.sv
/* stalling shift pipeline of pixel lanes, stand-in for the CNN core */
`timescale 1ns/1ps
`default_nettype none

module pixel_delay_line #(
   parameter int DELAY_STAGES = 10
)
(
   input  wire logic                  clk,
   input  wire logic                  cnn_rst_n,
   input  wire logic                  in_valid,
   input  wire cnn_stream_pkg::lane_t in_lane,
   input  wire logic                  out_ready,
   output logic                       in_ready,
   output logic                       out_valid,
   output cnn_stream_pkg::lane_t      out_lane
);

   cnn_stream_pkg::lane_t stage_data [DELAY_STAGES];
   logic [DELAY_STAGES-1:0] stage_valid;
   logic advance;

   // whole line moves when the last stage can leave or is a bubble
   assign advance = out_ready || !stage_valid[DELAY_STAGES-1];
   assign in_ready = advance;
   assign out_valid = stage_valid[DELAY_STAGES-1];
   assign out_lane = stage_data[DELAY_STAGES-1];

   always_ff @(posedge clk)
   begin
      if (!cnn_rst_n)
         stage_valid <= '0;
      else if (advance)
      begin
         stage_valid[0] <= in_valid;
         for (int i = 1; i < DELAY_STAGES; i++)
            stage_valid[i] <= stage_valid[i-1];
      end
   end

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         stage_data[0] <= in_lane;
         for (int i = 1; i < DELAY_STAGES; i++)
            stage_data[i] <= stage_data[i-1];
      end
   end

endmodule

`default_nettype wire

// File: logic/width_merger.sv
/* narrow lane to wide word merger, low lane first */
`timescale 1ns/1ps
`default_nettype none

module width_merger
(
   input  wire logic                  clk,
   input  wire logic                  cnn_rst_n,
   input  wire logic                  lane_valid,
   input  wire cnn_stream_pkg::lane_t lane_data,
   input  wire logic                  word_ready,
   output logic                       lane_ready,
   output logic                       word_valid,
   output cnn_stream_pkg::wide_word_t word_data
);

   localparam int IDX_W = cnn_stream_pkg::LANE_IDX_W;

   logic [IDX_W-1:0] lane_idx;
   logic lane_in;

   // no new lanes while a finished word waits
   assign lane_ready = !word_valid;
   assign lane_in = lane_valid && lane_ready;

   //------------------------------------------------------------
   // lane index and word valid
   //------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!cnn_rst_n)
      begin
         lane_idx   <= '0;
         word_valid <= 1'b0;
      end
      else if (lane_in)
      begin
         if (lane_idx == IDX_W'(cnn_stream_pkg::LANES - 1))
         begin
            lane_idx   <= '0;
            word_valid <= 1'b1;
         end
         else
            lane_idx <= lane_idx + IDX_W'(1);
      end
      else if (word_valid && word_ready)
         word_valid <= 1'b0;
   end

   // assembly by lane position
   always_ff @(posedge clk)
   begin
      if (lane_in)
         word_data[lane_idx*cnn_stream_pkg::LANE_W +: cnn_stream_pkg::LANE_W] <= lane_data;
   end

endmodule

`default_nettype wire

// File: logic/cnn_stream_top.sv
/* streaming image path top level: input FIFO and gate,
   lane splitter, delay line, merger, output FIFO and gate */
`timescale 1ns/1ps
`default_nettype none

module cnn_stream_top #(
   parameter int FIFO_DEPTH    = 32,
   parameter int IN_THRESHOLD  = 8,
   parameter int IN_BLOCK      = 8,
   parameter int OUT_THRESHOLD = 1,
   parameter int OUT_BLOCK     = 4,
   parameter int DELAY_STAGES  = 10
)
(
   input  wire logic                       clk,
   input  wire logic                       cnn_rst_n,
   input  wire logic                       in_valid,
   input  wire cnn_stream_pkg::wide_word_t in_data,
   input  wire logic                       out_ready,
   output logic                            in_ready,
   output logic                            out_valid,
   output cnn_stream_pkg::wide_word_t      out_data
);

   //------------------------------------------------------------
   // input side
   //------------------------------------------------------------
   logic in_full;
   logic in_nonempty;
   logic in_pop;
   cnn_stream_pkg::wide_word_t in_head;
   logic [cnn_ctrl_pkg::BLOCK_CNT_W-1:0] in_level;

   assign in_ready = !in_full;

   stream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_in_fifo (
      .clk       (clk),
      .cnn_rst_n (cnn_rst_n),
      .push      (in_valid),
      .push_data (in_data),
      .pop       (in_pop),
      .full      (in_full),
      .nonempty  (in_nonempty),
      .head_data (in_head),
      .level     (in_level)
   );

   // gated words towards the splitter
   logic blk_valid;
   logic blk_ready;
   cnn_stream_pkg::wide_word_t blk_data;

   block_gate #(.THRESHOLD(IN_THRESHOLD), .BLOCK_LEN(IN_BLOCK)) u_in_gate (
      .clk       (clk),
      .cnn_rst_n (cnn_rst_n),
      .level     (in_level),
      .nonempty  (in_nonempty),
      .head_data (in_head),
      .out_ready (blk_ready),
      .pop       (in_pop),
      .out_valid (blk_valid),
      .out_data  (blk_data)
   );

   //------------------------------------------------------------
   // lane path
   //------------------------------------------------------------
   logic pix_in_valid;
   logic pix_in_ready;
   cnn_stream_pkg::lane_t pix_in_lane;
   logic pix_out_valid;
   logic pix_out_ready;
   cnn_stream_pkg::lane_t pix_out_lane;

   width_splitter u_split (
      .clk        (clk),
      .cnn_rst_n  (cnn_rst_n),
      .word_valid (blk_valid),
      .word_data  (blk_data),
      .lane_ready (pix_in_ready),
      .word_ready (blk_ready),
      .lane_valid (pix_in_valid),
      .lane_data  (pix_in_lane)
   );

   pixel_delay_line #(.DELAY_STAGES(DELAY_STAGES)) u_delay (
      .clk       (clk),
      .cnn_rst_n (cnn_rst_n),
      .in_valid  (pix_in_valid),
      .in_lane   (pix_in_lane),
      .out_ready (pix_out_ready),
      .in_ready  (pix_in_ready),
      .out_valid (pix_out_valid),
      .out_lane  (pix_out_lane)
   );

   //------------------------------------------------------------
   // output side
   //------------------------------------------------------------
   logic mrg_valid;
   logic out_full;
   logic out_nonempty;
   logic out_pop;
   cnn_stream_pkg::wide_word_t mrg_data;
   cnn_stream_pkg::wide_word_t out_head;
   logic [cnn_ctrl_pkg::BLOCK_CNT_W-1:0] out_level;

   width_merger u_merge (
      .clk        (clk),
      .cnn_rst_n  (cnn_rst_n),
      .lane_valid (pix_out_valid),
      .lane_data  (pix_out_lane),
      .word_ready (!out_full),
      .lane_ready (pix_out_ready),
      .word_valid (mrg_valid),
      .word_data  (mrg_data)
   );

   stream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_out_fifo (
      .clk       (clk),
      .cnn_rst_n (cnn_rst_n),
      .push      (mrg_valid),
      .push_data (mrg_data),
      .pop       (out_pop),
      .full      (out_full),
      .nonempty  (out_nonempty),
      .head_data (out_head),
      .level     (out_level)
   );

   block_gate #(.THRESHOLD(OUT_THRESHOLD), .BLOCK_LEN(OUT_BLOCK)) u_out_gate (
      .clk       (clk),
      .cnn_rst_n (cnn_rst_n),
      .level     (out_level),
      .nonempty  (out_nonempty),
      .head_data (out_head),
      .out_ready (out_ready),
      .pop       (out_pop),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

endmodule

`default_nettype wire

// File: sim/cnn_stream_assertions.sv
/* concurrent checks on the top-level stream handshakes,
   bound into cnn_stream_top */
`timescale 1ns/1ps
`default_nettype none

module cnn_stream_assertions
(
   input wire logic                       clk,
   input wire logic                       cnn_rst_n,
   input wire logic                       in_ready,
   input wire logic                       out_valid,
   input wire logic                       out_ready,
   input wire cnn_stream_pkg::wide_word_t out_data
);

   // stalled output word stays put
   property out_hold_p;
      @(posedge clk) disable iff (!cnn_rst_n)
         (out_valid && !out_ready) |=> (out_valid && $stable(out_data));
   endproperty

   // gates come out of reset idle
   property out_idle_after_reset_p;
      @(posedge clk) !cnn_rst_n |=> !out_valid;
   endproperty

   // input FIFO refuses words while in reset
   property in_blocked_in_reset_p;
      @(posedge clk) !cnn_rst_n |=> !in_ready;
   endproperty

   out_hold_a: assert property (out_hold_p)
      else $error("output word changed while stalled");
   out_idle_after_reset_a: assert property (out_idle_after_reset_p)
      else $error("out_valid high after reset");
   in_blocked_in_reset_a: assert property (in_blocked_in_reset_p)
      else $error("in_ready high during reset");

endmodule

bind cnn_stream_top cnn_stream_assertions u_assert (.*);

`default_nettype wire

// File: sim/tb_cnn_stream.sv
/* testbench for the streaming image path: phase table, scoreboard
   queue, word and count checks, cycle timeout */
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_stream;

   localparam int NUM_PHASES     = 5;
   localparam int SEED           = 32'h0968e55b;
   localparam int TIMEOUT_MARGIN = 200;
   localparam int SETTLE_CYCLES  = 50;

   logic clk;
   logic cnn_rst_n;
   logic in_valid;
   cnn_stream_pkg::wide_word_t in_data;
   logic out_ready;
   logic in_ready;
   logic out_valid;
   cnn_stream_pkg::wide_word_t out_data;

   // phase table: name, words sent, input valid %, output ready %,
   // total words out expected once the phase has settled
   string phase_name    [NUM_PHASES];
   int    phase_words   [NUM_PHASES];
   int    phase_in_pct  [NUM_PHASES];
   int    phase_out_pct [NUM_PHASES];
   int    phase_exp_out [NUM_PHASES];

   cnn_stream_pkg::wide_word_t exp_q [$];
   string cur_name;
   int out_count;
   int total_in;
   int cycle_count;
   int cycle_limit;
   logic saw_full;

   cnn_stream_top DUT (
      .clk       (clk),
      .cnn_rst_n (cnn_rst_n),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .out_ready (out_ready),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   //------------------------------------------------------------
   // helpers
   //------------------------------------------------------------
   task automatic check_value(input string test_name,
                              input logic [cnn_stream_pkg::WIDE_W-1:0] expected,
                              input logic [cnn_stream_pkg::WIDE_W-1:0] actual);
      if (expected !== actual)
      begin
         $display("Error: %s expected %0h actual %0h", test_name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic cnn_stream_pkg::wide_word_t random_word();
      cnn_stream_pkg::wide_word_t w;
      for (int i = 0; i < cnn_stream_pkg::WIDE_W / 32; i++)
         w[i*32 +: 32] = $urandom;
      return w;
   endfunction

   // 0 % means hold low until the input port has backed up
   function automatic logic pick_ready(input int pct);
      logic r;
      if (pct == 0)
         r = saw_full;
      else
         r = ($urandom_range(99) < pct);
      return r;
   endfunction

   //------------------------------------------------------------
   // timeout and output scoreboard
   //------------------------------------------------------------
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit)
      begin
         $display("run stopped after %0d cycles, output did not drain", cycle_count);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   // values at the falling edge are the ones seen by the next rising edge
   always @(negedge clk)
   begin
      if (cnn_rst_n && out_valid && out_ready)
      begin
         if (exp_q.size() == 0)
         begin
            $display("Error: %s produced an output word with no input outstanding",
                     cur_name);
            $display("TEST FAILED");
            $fatal(1, "unexpected output word");
         end
         else
         begin
            check_value(cur_name, exp_q.pop_front(), out_data);
            out_count++;
         end
      end
   end

   task automatic run_phase(input int idx);
      int sent;
      logic pending;
      sent = 0;
      pending = 1'b0;
      saw_full = 1'b0;
      cur_name = phase_name[idx];
      while (sent < phase_words[idx])
      begin
         @(posedge clk);
         #1;
         out_ready = pick_ready(phase_out_pct[idx]);
         // a word on offer holds until it is taken
         if (!pending)
         begin
            if ($urandom_range(99) < phase_in_pct[idx])
            begin
               in_data  = random_word();
               in_valid = 1'b1;
               pending  = 1'b1;
            end
            else
               in_valid = 1'b0;
         end
         @(negedge clk);
         if (!in_ready)
            saw_full = 1'b1;
         if (in_valid && in_ready)
         begin
            exp_q.push_back(in_data);
            sent++;
            total_in++;
            pending = 1'b0;
         end
      end
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      if (phase_out_pct[idx] == 0)
         check_value(cur_name, 1, saw_full);
      while (out_count < phase_exp_out[idx])
      begin
         out_ready = pick_ready(phase_out_pct[idx]);
         @(posedge clk);
         #1;
      end
      // nothing extra may follow
      repeat (SETTLE_CYCLES)
      begin
         out_ready = pick_ready(phase_out_pct[idx]);
         @(posedge clk);
         #1;
      end
      check_value(cur_name, phase_exp_out[idx], out_count);
   endtask

   //------------------------------------------------------------
   // main sequence
   //------------------------------------------------------------
   initial
   begin
      int total;
      void'($urandom(SEED));
      phase_name[0]    = "below_threshold";
      phase_words[0]   = 5;
      phase_in_pct[0]  = 100;
      phase_out_pct[0] = 100;
      phase_exp_out[0] = 0;
      phase_name[1]    = "pass_through";
      phase_words[1]   = 19;
      phase_in_pct[1]  = 100;
      phase_out_pct[1] = 100;
      phase_exp_out[1] = 24;
      phase_name[2]    = "random_stall";
      phase_words[2]   = 24;
      phase_in_pct[2]  = 100;
      phase_out_pct[2] = 50;
      phase_exp_out[2] = 48;
      phase_name[3]    = "sustained_stall";
      phase_words[3]   = 96;
      phase_in_pct[3]  = 100;
      phase_out_pct[3] = 0;
      phase_exp_out[3] = 144;
      phase_name[4]    = "random_gaps";
      phase_words[4]   = 64;
      phase_in_pct[4]  = 60;
      phase_out_pct[4] = 60;
      phase_exp_out[4] = 208;
      total = 0;
      for (int i = 0; i < NUM_PHASES; i++)
         total += phase_words[i];
      cycle_limit = 20 * total + TIMEOUT_MARGIN;
      cycle_count = 0;
      out_count = 0;
      total_in = 0;
      saw_full = 1'b0;
      cur_name = "reset";
      cnn_rst_n = 1'b0;
      in_valid = 1'b0;
      in_data = '0;
      out_ready = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      cnn_rst_n = 1'b1;
      out_ready = 1'b1;
      @(posedge clk);
      @(negedge clk);
      check_value("reset", 1, in_ready);
      check_value("reset", 0, out_valid);
      for (int i = 0; i < NUM_PHASES; i++)
         run_phase(i);
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
logic/cnn_stream_pkg.sv
logic/cnn_ctrl_pkg.sv
logic/stream_fifo.sv
logic/block_gate.sv
logic/width_splitter.sv
logic/pixel_delay_line.sv
logic/width_merger.sv
logic/cnn_stream_top.sv
sim/cnn_stream_assertions.sv
sim/tb_cnn_stream.sv
